// File: all.f
verilog/telemetry_pkg.sv
verilog/telemetry_change_capture.sv
verilog/telemetry_frame_counter.sv
verilog/telemetry_sync_fifo.sv
verilog/telemetry_byte_serializer.sv
verilog/telemetry_readout_fsm.sv
verilog/bulk_telemetry.sv
tb/bulk_telemetry_checker.sv
tb/bulk_telemetry_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= bulk_telemetry_tb
FILELIST ?= all.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/bulk_telemetry_tb.sv
`timescale 1ns/1ps
module bulk_telemetry_tb;
  import telemetry_pkg::*;

  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_START_OWN,
    CMD_START_OTHER,
    CMD_START_NOSEL
  } command_t;

  // Rows with several repeats step blk_state once per cycle
  typedef struct packed {
    logic       usb_enum;
    logic       crc_error;
    logic [3:0] usb_state;
    logic [3:0] ctl_state;
    logic [7:0] blk_state;
    command_t   command;
    logic [4:0] repeats;
    logic [5:0] exp_bytes;
  } stim_row_t;

  localparam int NUM_ROWS = 17;
  localparam int FRAME_TIMEOUT = 300;
  localparam int QUIET_WINDOW = 12;

  stim_row_t stim_table [NUM_ROWS] = '{
    '{1'b0, 1'b0, 4'h0, 4'h0, 8'h00, CMD_NONE,        5'd4,  6'd0},
    '{1'b0, 1'b1, 4'h3, 4'h5, 8'h10, CMD_NONE,        5'd3,  6'd0},
    '{1'b1, 1'b1, 4'h3, 4'h5, 8'h12, CMD_NONE,        5'd1,  6'd0},
    '{1'b1, 1'b1, 4'h3, 4'h5, 8'h12, CMD_NONE,        5'd1,  6'd0},
    '{1'b1, 1'b0, 4'h4, 4'h1, 8'h20, CMD_NONE,        5'd8,  6'd0},
    '{1'b1, 1'b0, 4'h4, 4'h1, 8'h27, CMD_START_OTHER, 5'd1,  6'd0},
    '{1'b1, 1'b0, 4'h4, 4'h1, 8'h27, CMD_START_NOSEL, 5'd1,  6'd0},
    '{1'b1, 1'b0, 4'h4, 4'h1, 8'h27, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b1, 1'b1, 4'h9, 4'h2, 8'h40, CMD_NONE,        5'd16, 6'd0},
    '{1'b1, 1'b1, 4'h9, 4'h2, 8'h4f, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b1, 1'b1, 4'h9, 4'h2, 8'h4f, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b1, 1'b0, 4'h6, 4'h7, 8'h80, CMD_NONE,        5'd20, 6'd0},
    '{1'b1, 1'b0, 4'h6, 4'h7, 8'h93, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b1, 1'b0, 4'h6, 4'h7, 8'h93, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b1, 1'b1, 4'h2, 4'h3, 8'hc0, CMD_NONE,        5'd7,  6'd0},
    '{1'b1, 1'b1, 4'h2, 4'h3, 8'hc6, CMD_START_OWN,   5'd1,  6'd24},
    '{1'b0, 1'b0, 4'h0, 4'h0, 8'h00, CMD_NONE,        5'd4,  6'd0}
  };

  logic                clock = 1'b0;
  logic                reset;
  logic                usb_enum;
  logic                crc_error;
  logic [3:0]          usb_state;
  logic [3:0]          ctl_state;
  logic [7:0]          blk_state;
  logic                select;
  logic                start;
  logic [3:0]          endpt;
  logic                m_tvalid;
  logic                m_tready;
  logic                m_tlast;
  logic [7:0]          m_tdata;
  logic [FIFO_ABITS:0] level;
  logic                error;
  integer              seed = 32'h23fb;
  int                  tb_errors;
  int                  checker_errors;
  int                  bytes_seen;
  int                  pending;

  always #2 clock = ~clock;

  bulk_telemetry i_bulk_telemetry (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum),
    .crc_error_i (crc_error),
    .usb_state_i (usb_state),
    .ctl_state_i (ctl_state),
    .blk_state_i (blk_state),
    .select_i    (select),
    .start_i     (start),
    .endpt_i     (endpt),
    .m_tvalid_o  (m_tvalid),
    .m_tready_i  (m_tready),
    .m_tlast_o   (m_tlast),
    .m_tdata_o   (m_tdata),
    .level_o     (level),
    .error_o     (error)
  );

  bulk_telemetry_checker u_checker (
    .clock         (clock),
    .reset         (reset),
    .usb_enum_i    (usb_enum),
    .crc_error_i   (crc_error),
    .usb_state_i   (usb_state),
    .ctl_state_i   (ctl_state),
    .blk_state_i   (blk_state),
    .select_i      (select),
    .start_i       (start),
    .endpt_i       (endpt),
    .m_tvalid_i    (m_tvalid),
    .m_tready_i    (m_tready),
    .m_tlast_i     (m_tlast),
    .m_tdata_i     (m_tdata),
    .level_i       (level),
    .error_i       (error),
    .error_count_o (checker_errors),
    .bytes_seen_o  (bytes_seen),
    .pending_o     (pending)
  );

  task automatic draw_ready();
    logic [31:0] rand_word;
    rand_word = $random(seed);
    m_tready = rand_word[0];
  endtask

  task automatic drive_row(input stim_row_t row, input int rep);
    usb_enum = row.usb_enum;
    crc_error = row.crc_error;
    usb_state = row.usb_state;
    ctl_state = row.ctl_state;
    blk_state = row.blk_state + 8'(rep);
    select = (row.command == CMD_START_OWN) || (row.command == CMD_START_OTHER);
    start = (row.command != CMD_NONE);
    endpt = (row.command == CMD_START_OTHER) ? ENDPOINT_ID + 4'd3 : ENDPOINT_ID;
    draw_ready();
  endtask

  // Counts accepted bytes until a last byte or the end of the window
  task automatic collect_bytes(input logic want_frame, input int exp_bytes);
    int first_count;
    int cycles;
    int limit;
    logic done;
    first_count = bytes_seen;
    cycles = 0;
    done = 1'b0;
    limit = want_frame ? FRAME_TIMEOUT : QUIET_WINDOW;
    while (!done && cycles < limit) begin
      @(posedge clock);
      done = want_frame && m_tvalid && m_tready && m_tlast;
      @(negedge clock);
      start = 1'b0;
      select = 1'b0;
      draw_ready();
      cycles++;
    end
    if (want_frame && !done) begin
      $display("Timeout: no last byte within %0d cycles of a start", FRAME_TIMEOUT);
      tb_errors++;
    end else if (bytes_seen - first_count != exp_bytes) begin
      $display("ERROR at %0d ns: %0d bytes after start, expected %0d", $time,
               bytes_seen - first_count, exp_bytes);
      tb_errors++;
    end
  endtask

  initial begin
    reset = 1'b1;
    usb_enum = 1'b0;
    crc_error = 1'b0;
    usb_state = 4'h0;
    ctl_state = 4'h0;
    blk_state = 8'h00;
    select = 1'b0;
    start = 1'b0;
    endpt = 4'h0;
    m_tready = 1'b0;
    tb_errors = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int k = 0; k < int'(stim_table[r].repeats); k++) begin
        @(negedge clock);
        drive_row(stim_table[r], k);
      end
      if (stim_table[r].command != CMD_NONE) begin
        collect_bytes(stim_table[r].command == CMD_START_OWN,
                      int'(stim_table[r].exp_bytes));
      end
    end
    repeat (2) @(negedge clock);

    if (pending != 0) begin
      $display("ERROR at %0d ns: %0d records never read out", $time, pending);
      tb_errors++;
    end
    $display("Errors: %0d from checker, %0d from stimulus, %0d bytes checked",
             checker_errors, tb_errors, bytes_seen);
    if (checker_errors + tb_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: tb/bulk_telemetry_checker.sv
`timescale 1ns/1ps
module bulk_telemetry_checker (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              usb_enum_i,
  input  logic                              crc_error_i,
  input  logic [3:0]                        usb_state_i,
  input  logic [3:0]                        ctl_state_i,
  input  logic [7:0]                        blk_state_i,
  input  logic                              select_i,
  input  logic                              start_i,
  input  logic [3:0]                        endpt_i,
  input  logic                              m_tvalid_i,
  input  logic                              m_tready_i,
  input  logic                              m_tlast_i,
  input  logic [7:0]                        m_tdata_i,
  input  logic [telemetry_pkg::FIFO_ABITS:0] level_i,
  input  logic                              error_i,
  output int                                error_count_o,
  output int                                bytes_seen_o,
  output int                                pending_o
);
  import telemetry_pkg::*;

  localparam int DEPTH = 1 << FIFO_ABITS;

  frame_entry_t      expect_q[$];
  frame_entry_t      new_entry;
  frame_entry_t      head;
  telemetry_record_t status_w;
  telemetry_record_t prev_status;
  int                fifo_count;
  int                frame_pos;
  int                byte_idx;
  logic              ser_busy;
  logic              selected;
  logic              sticky_error;
  logic              strobe;
  logic              push;
  logic              pop;
  logic              accept_byte;
  logic              start_ok;
  logic [7:0]        exp_data;
  logic              exp_last;

  assign status_w = {crc_error_i, usb_state_i, ctl_state_i, blk_state_i};

  // Byte layout of one record on the stream
  function automatic logic [7:0] format_byte(telemetry_record_t rec, int idx);
    logic [7:0] b;
    case (idx)
      0:       b = {rec.crc_error, 3'b000, rec.usb_state};
      1:       b = {4'h0, rec.ctl_state};
      default: b = rec.blk_state;
    endcase
    return b;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    error_count_o++;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      expect_q.delete();
      prev_status = '0;
      fifo_count = 0;
      frame_pos = 0;
      byte_idx = 0;
      ser_busy = 1'b0;
      selected = 1'b0;
      sticky_error = 1'b0;
    end else begin
      if (level_i !== (FIFO_ABITS+1)'(fifo_count)) begin
        flag_mismatch($sformatf("level_o is %0d, expected %0d", level_i, fifo_count));
      end
      if (error_i !== sticky_error) begin
        flag_mismatch($sformatf("error_o is %b, expected %b", error_i, sticky_error));
      end
      if (m_tvalid_i !== (selected && ser_busy)) begin
        flag_mismatch($sformatf("m_tvalid_o is %b, expected %b", m_tvalid_i,
                                selected && ser_busy));
      end
      accept_byte = selected && ser_busy && m_tready_i;
      if (accept_byte) begin
        head = expect_q[0];
        exp_data = format_byte(head.record, byte_idx);
        exp_last = head.frame_last && (byte_idx == BYTES_PER_RECORD - 1);
        if (m_tdata_i !== exp_data || m_tlast_i !== exp_last) begin
          flag_mismatch($sformatf("byte %0d is %h last %b, expected %h last %b",
                                  bytes_seen_o, m_tdata_i, m_tlast_i, exp_data, exp_last));
        end
        bytes_seen_o++;
      end

      pop = (fifo_count > 0) &&
            (!ser_busy || (accept_byte && byte_idx == BYTES_PER_RECORD - 1));
      strobe = usb_enum_i && (status_w != prev_status);
      push = strobe && (fifo_count < DEPTH);
      if (strobe && !push) begin
        sticky_error = 1'b1;
      end
      start_ok = start_i && select_i && usb_enum_i && (endpt_i == ENDPOINT_ID);

      if (!selected) begin
        selected = start_ok;
      end else if (accept_byte && exp_last) begin
        selected = 1'b0;
      end

      // Serializer slot holds the oldest record
      if (accept_byte) begin
        if (byte_idx == BYTES_PER_RECORD - 1) begin
          byte_idx = 0;
          ser_busy = 1'b0;
          void'(expect_q.pop_front());
        end else begin
          byte_idx++;
        end
      end
      if (pop) begin
        ser_busy = 1'b1;
      end

      if (push) begin
        new_entry.frame_last = (frame_pos == RECORDS_PER_FRAME - 1);
        new_entry.record = status_w;
        expect_q.push_back(new_entry);
        frame_pos = (frame_pos + 1) % RECORDS_PER_FRAME;
      end
      fifo_count = fifo_count + int'(push) - int'(pop);
      prev_status = status_w;
    end
    pending_o = expect_q.size();
  end

endmodule

// File: verilog/bulk_telemetry.sv
`timescale 1ns/1ps
module bulk_telemetry (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              usb_enum_i,
  input  logic                              crc_error_i,
  input  logic [3:0]                        usb_state_i,
  input  logic [3:0]                        ctl_state_i,
  input  logic [7:0]                        blk_state_i,
  input  logic                              select_i,
  input  logic                              start_i,
  input  logic [3:0]                        endpt_i,
  output logic                              m_tvalid_o,
  input  logic                              m_tready_i,
  output logic                              m_tlast_o,
  output logic [7:0]                        m_tdata_o,
  output logic [telemetry_pkg::FIFO_ABITS:0] level_o,
  output logic                              error_o
);
  import telemetry_pkg::*;

  logic              record_valid_w;
  telemetry_record_t record_w;
  logic              fifo_full_w;
  logic              write_w;
  logic              frame_last_w;
  frame_entry_t      wr_entry_w;

  logic              entry_valid_w;
  logic              entry_ready_w;
  frame_entry_t      rd_entry_w;

  logic              beat_valid_w;
  logic              beat_ready_w;
  byte_beat_t        beat_w;

  logic              error_q;

  telemetry_change_capture u_capture (
    .clock          (clock),
    .reset          (reset),
    .usb_enum_i     (usb_enum_i),
    .crc_error_i    (crc_error_i),
    .usb_state_i    (usb_state_i),
    .ctl_state_i    (ctl_state_i),
    .blk_state_i    (blk_state_i),
    .record_valid_o (record_valid_w),
    .record_o       (record_w)
  );

  // Records that meet a full FIFO are dropped
  assign write_w = record_valid_w && !fifo_full_w;

  telemetry_frame_counter u_frame_counter (
    .clock        (clock),
    .reset        (reset),
    .advance_i    (write_w),
    .frame_last_o (frame_last_w)
  );

  assign wr_entry_w.frame_last = frame_last_w;
  assign wr_entry_w.record = record_w;

  telemetry_sync_fifo #(
    .payload_t (frame_entry_t)
  ) u_fifo (
    .clock   (clock),
    .reset   (reset),
    .write_i (write_w),
    .data_i  (wr_entry_w),
    .full_o  (fifo_full_w),
    .level_o (level_o),
    .valid_o (entry_valid_w),
    .ready_i (entry_ready_w),
    .data_o  (rd_entry_w)
  );

  telemetry_byte_serializer u_serializer (
    .clock         (clock),
    .reset         (reset),
    .entry_valid_i (entry_valid_w),
    .entry_ready_o (entry_ready_w),
    .entry_i       (rd_entry_w),
    .beat_valid_o  (beat_valid_w),
    .beat_ready_i  (beat_ready_w),
    .beat_o        (beat_w)
  );

  telemetry_readout_fsm u_readout (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .select_i     (select_i),
    .start_i      (start_i),
    .endpt_i      (endpt_i),
    .beat_valid_i (beat_valid_w),
    .beat_ready_o (beat_ready_w),
    .beat_i       (beat_w),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o)
  );

  // Sticky overflow flag that only reset clears
  always_ff @(posedge clock) begin
    if (reset) begin
      error_q <= 1'b0;
    end else if (record_valid_w && fifo_full_w) begin
      error_q <= 1'b1;
    end
  end

  assign error_o = error_q;

endmodule

// File: verilog/telemetry_readout_fsm.sv
`timescale 1ns/1ps
module telemetry_readout_fsm (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      usb_enum_i,
  input  logic                      select_i,
  input  logic                      start_i,
  input  logic [3:0]                endpt_i,
  input  logic                      beat_valid_i,
  output logic                      beat_ready_o,
  input  telemetry_pkg::byte_beat_t beat_i,
  output logic                      m_tvalid_o,
  input  logic                      m_tready_i,
  output logic                      m_tlast_o,
  output logic [7:0]                m_tdata_o
);
  import telemetry_pkg::*;

  typedef enum logic {
    IDLE,
    STREAMING
  } state_t;

  state_t state_q;
  logic   start_ok_w;
  logic   streaming_w;
  logic   end_of_frame_w;

  // Host start must name this endpoint
  assign start_ok_w = start_i && select_i && usb_enum_i && (endpt_i == ENDPOINT_ID);
  assign streaming_w = (state_q == STREAMING);
  assign end_of_frame_w = m_tvalid_o && m_tready_i && m_tlast_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_ok_w) begin
            state_q <= STREAMING;
          end
        end
        STREAMING: begin
          if (end_of_frame_w) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Handshake only passes while selected
  assign m_tvalid_o = streaming_w && beat_valid_i;
  assign beat_ready_o = streaming_w && m_tready_i;
  assign m_tlast_o = streaming_w && beat_i.last;
  assign m_tdata_o = streaming_w ? beat_i.data : 8'h00;

endmodule

// File: verilog/telemetry_byte_serializer.sv
`timescale 1ns/1ps
module telemetry_byte_serializer (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        entry_valid_i,
  output logic                        entry_ready_o,
  input  telemetry_pkg::frame_entry_t entry_i,
  output logic                        beat_valid_o,
  input  logic                        beat_ready_i,
  output telemetry_pkg::byte_beat_t   beat_o
);
  import telemetry_pkg::*;

  localparam int IW = $clog2(BYTES_PER_RECORD);
  localparam logic [IW-1:0] LAST_IDX = IW'(BYTES_PER_RECORD - 1);

  frame_entry_t  entry_q;
  logic          busy_q;
  logic [IW-1:0] index_q;
  logic          beat_done_w;
  logic          load_w;

  assign beat_done_w = busy_q && beat_ready_i;
  // Free when empty, or when the final byte is leaving this cycle
  assign entry_ready_o = !busy_q || (beat_done_w && index_q == LAST_IDX);
  assign load_w = entry_valid_i && entry_ready_o;

  // Entry being serialized
  always_ff @(posedge clock) begin
    if (load_w) begin
      entry_q <= entry_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q  <= 1'b0;
      index_q <= '0;
    end else if (load_w) begin
      busy_q  <= 1'b1;
      index_q <= '0;
    end else if (beat_done_w) begin
      if (index_q == LAST_IDX) begin
        busy_q  <= 1'b0;
        index_q <= '0;
      end else begin
        index_q <= index_q + 1'b1;
      end
    end
  end

  // Byte format per record index
  always_comb begin
    case (index_q)
      2'd0:    beat_o.data = {entry_q.record.crc_error, 3'b000, entry_q.record.usb_state};
      2'd1:    beat_o.data = {4'b0000, entry_q.record.ctl_state};
      default: beat_o.data = entry_q.record.blk_state;
    endcase
    beat_o.last = entry_q.frame_last && (index_q == LAST_IDX);
  end

  assign beat_valid_o = busy_q;

  a_beat_stable : assert property (
    @(posedge clock) disable iff (reset)
    beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o)
  );

endmodule

// File: verilog/telemetry_sync_fifo.sv
`timescale 1ns/1ps
module telemetry_sync_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            write_i,
  input  payload_t                        data_i,
  output logic                            full_o,
  output logic [telemetry_pkg::FIFO_ABITS:0] level_o,
  output logic                            valid_o,
  input  logic                            ready_i,
  output payload_t                        data_o
);
  import telemetry_pkg::*;

  localparam int DEPTH = 1 << FIFO_ABITS;

  payload_t mem [DEPTH];

  logic [FIFO_ABITS-1:0] wr_ptr_q;
  logic [FIFO_ABITS-1:0] rd_ptr_q;
  logic [FIFO_ABITS:0]   count_q;
  logic                  push_w;
  logic                  pop_w;

  assign push_w = write_i;
  assign pop_w = valid_o && ready_i;

  // Storage array
  always_ff @(posedge clock) begin
    if (push_w) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry falls through straight from the array
  assign valid_o = (count_q != '0);
  assign data_o = mem[rd_ptr_q];
  assign full_o = (count_q == (FIFO_ABITS+1)'(DEPTH));
  assign level_o = count_q;

  a_no_write_when_full : assert property (
    @(posedge clock) disable iff (reset)
    full_o |-> !write_i
  );

  a_level_in_range : assert property (
    @(posedge clock) disable iff (reset)
    level_o <= (FIFO_ABITS+1)'(DEPTH)
  );

endmodule

// File: verilog/telemetry_frame_counter.sv
`timescale 1ns/1ps
module telemetry_frame_counter (
  input  logic clock,
  input  logic reset,
  input  logic advance_i,
  output logic frame_last_o
);
  import telemetry_pkg::*;

  localparam int CW = $clog2(RECORDS_PER_FRAME);
  localparam logic [CW-1:0] LAST_POS = CW'(RECORDS_PER_FRAME - 1);

  logic [CW-1:0] count_q;

  // Position of the next accepted record within its frame
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (advance_i) begin
      if (count_q == LAST_POS) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign frame_last_o = (count_q == LAST_POS);

endmodule

// File: verilog/telemetry_change_capture.sv
`timescale 1ns/1ps
module telemetry_change_capture (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             usb_enum_i,
  input  logic                             crc_error_i,
  input  logic [3:0]                       usb_state_i,
  input  logic [3:0]                       ctl_state_i,
  input  logic [7:0]                       blk_state_i,
  output logic                             record_valid_o,
  output telemetry_pkg::telemetry_record_t record_o
);
  import telemetry_pkg::*;

  telemetry_record_t current_w;
  telemetry_record_t previous_q;

  assign current_w.crc_error = crc_error_i;
  assign current_w.usb_state = usb_state_i;
  assign current_w.ctl_state = ctl_state_i;
  assign current_w.blk_state = blk_state_i;

  // Status as seen on the previous clock
  always_ff @(posedge clock) begin
    if (reset) begin
      previous_q <= '0;
    end else begin
      previous_q <= current_w;
    end
  end

  // Any field change counts, but only once enumerated
  assign record_valid_o = usb_enum_i && (current_w != previous_q);
  assign record_o = current_w;

  // Strobe follows every status change seen while enumerated, and nothing else
  a_strobe_on_change : assert property (
    @(posedge clock) disable iff (reset)
    !$past(reset) |-> record_valid_o == (usb_enum_i && $changed(record_o))
  );

endmodule

// File: verilog/telemetry_pkg.sv
package telemetry_pkg;

  // Endpoint number that a start strobe must name
  localparam logic [3:0] ENDPOINT_ID = 4'd2;

  localparam int RECORDS_PER_FRAME = 8;
  localparam int BYTES_PER_RECORD = 3;

  // FIFO depth is 2**FIFO_ABITS entries
  localparam int FIFO_ABITS = 4;

  // One snapshot of the USB core status
  typedef struct packed {
    logic       crc_error;
    logic [3:0] usb_state;
    logic [3:0] ctl_state;
    logic [7:0] blk_state;
  } telemetry_record_t;

  // FIFO payload of a record and its end-of-frame marker
  typedef struct packed {
    logic              frame_last;
    telemetry_record_t record;
  } frame_entry_t;

  // One byte of the output stream
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

endpackage
